// File: filelist.f
+incdir+.
lsu_pkg.sv
lsu_skid.sv
lsu_stq.sv
lsu_dmem.sv
lsu_ld_merge.sv
lsu_top.sv
tb_lsu_top.sv

// File: run.sh
#!/bin/sh
# Build and run the LSU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_lsu_top -f filelist.f -o tb_lsu_top

out=$(./obj_dir/tb_lsu_top 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "All tests passed"; then
  exit 0
fi
exit 1

// File: tb_lsu_checks.svh
`ifndef TB_LSU_CHECKS_SVH
`define TB_LSU_CHECKS_SVH

// ======================================================================
// Error counters and compare tasks
// ======================================================================
int data_errs  = 0;  // Wrong data words
int bit_errs   = 0;  // Wrong status or handshake bits
int other_errs = 0;

task automatic check_data(input string name, input lsu_pkg::data_t got,
                          input lsu_pkg::data_t exp);
  if (got !== exp) begin
    data_errs++;
    $display("Mismatch at %0t ns: %s got 0x%h, expected 0x%h", $time, name, got, exp);
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    bit_errs++;
    $display("Mismatch at %0t ns: %s got %b, expected %b", $time, name, got, exp);
  end
endtask

// Anything that is not a plain value compare
task automatic report_problem(input string what);
  other_errs++;
  $display("Error at %0t ns: %s", $time, what);
endtask

function automatic int total_errors();
  return data_errs + bit_errs + other_errs;
endfunction

`endif

// File: tb_lsu_top.sv
`timescale 1ns/1ns

module tb_lsu_top;

  typedef enum logic [2:0] {op_store, op_commit, op_flush, op_load, op_idle} op_e;

  typedef struct packed {
    op_e            kind;
    lsu_pkg::addr_t addr;
    lsu_pkg::data_t data;
    lsu_pkg::be_t   be;
    lsu_pkg::data_t exp;  // Load data, or store ready in bit 0, load ready in bit 1
  } row_t;

  logic           i_clk;
  logic           i_reset_n;
  logic           i_st_valid;
  logic           o_st_ready;
  lsu_pkg::addr_t i_st_addr;
  lsu_pkg::data_t i_st_data;
  lsu_pkg::be_t   i_st_be;
  logic           i_ld_valid;
  logic           o_ld_ready;
  lsu_pkg::addr_t i_ld_addr;
  logic           o_ld_valid;
  logic           i_ld_ready;
  lsu_pkg::data_t o_ld_data;
  logic           i_commit;
  logic           i_flush;

  row_t             rows[$];
  lsu_pkg::data_t   exp_q[$];  // Responses still owed, oldest first
  lsu_pkg::data_t   model_mem [lsu_pkg::MEM_WORDS];
  lsu_pkg::st_req_t model_q[$];  // Uncommitted stores in program order
  bit               table_ready = 1'b0;

  `include "tb_lsu_checks.svh"

  lsu_top dut (
    .i_clk(i_clk), .i_reset_n(i_reset_n),
    .i_st_valid(i_st_valid), .o_st_ready(o_st_ready),
    .i_st_addr(i_st_addr), .i_st_data(i_st_data), .i_st_be(i_st_be),
    .i_ld_valid(i_ld_valid), .o_ld_ready(o_ld_ready), .i_ld_addr(i_ld_addr),
    .o_ld_valid(o_ld_valid), .i_ld_ready(i_ld_ready), .o_ld_data(o_ld_data),
    .i_commit(i_commit), .i_flush(i_flush)
  );

  // ======================================================================
  // Reference model and table
  // ======================================================================
  // Memory with the committed stores, overlaid by queued ones old to young
  function automatic lsu_pkg::data_t predict_load(lsu_pkg::addr_t addr);
    lsu_pkg::data_t word;
    word = model_mem[addr];
    foreach (model_q[i]) begin
      for (int b = 0; b < lsu_pkg::BE_W; b++) begin
        if (model_q[i].addr == addr && model_q[i].be[b]) begin
          word[b*8 +: 8] = model_q[i].data[b*8 +: 8];
        end
      end
    end
    return word;
  endfunction

  function automatic void add_row(op_e kind, lsu_pkg::addr_t addr, lsu_pkg::data_t data,
                                  lsu_pkg::be_t be, lsu_pkg::data_t exp, bit auto_exp);
    row_t             r;
    lsu_pkg::st_req_t s;
    r = '{kind: kind, addr: addr, data: data, be: be, exp: exp};
    case (kind)
      op_store: model_q.push_back('{addr: addr, data: data, be: be});
      op_commit: begin
        s = model_q.pop_front();  // Committed stores count as memory from now on
        for (int b = 0; b < lsu_pkg::BE_W; b++) begin
          if (s.be[b]) model_mem[s.addr][b*8 +: 8] = s.data[b*8 +: 8];
        end
      end
      op_flush: model_q.delete();
      op_load:  if (auto_exp) r.exp = predict_load(addr);
      default: ;
    endcase
    rows.push_back(r);
  endfunction

  function automatic void build_table();
    lsu_pkg::addr_t addr;
    int unsigned    pick;
    foreach (model_mem[w]) model_mem[w] = '0;
    add_row(op_idle, 8'h00, '0, '0, 32'd3, 1'b0);
    add_row(op_load, 8'h10, '0, '0, 32'h0000_0000, 1'b0);  // Never written
    // Store, commit and drain, then read back over zero bytes
    add_row(op_store, 8'h20, 32'hAABB_CCDD, 4'b0101, '0, 1'b0);
    add_row(op_commit, 8'h00, '0, '0, '0, 1'b0);
    add_row(op_load, 8'h20, '0, '0, 32'h00BB_00DD, 1'b0);
    // Youngest matching store per byte
    add_row(op_store, 8'h30, 32'h1111_1111, 4'b1111, '0, 1'b0);
    add_row(op_store, 8'h30, 32'h2222_2222, 4'b0011, '0, 1'b0);
    add_row(op_store, 8'h30, 32'h3333_3333, 4'b0001, '0, 1'b0);
    add_row(op_store, 8'h20, 32'h5500_0000, 4'b1000, '0, 1'b0);
    add_row(op_load, 8'h30, '0, '0, 32'h1111_2233, 1'b0);
    add_row(op_load, 8'h20, '0, '0, 32'h55BB_00DD, 1'b0);
    // Flush keeps only the committed head
    add_row(op_commit, 8'h00, '0, '0, '0, 1'b0);
    add_row(op_flush, 8'h00, '0, '0, '0, 1'b0);
    add_row(op_load, 8'h30, '0, '0, 32'h1111_1111, 1'b0);
    add_row(op_load, 8'h20, '0, '0, 32'h00BB_00DD, 1'b0);
    // Queue full plus both skid slots
    for (int i = 0; i < lsu_pkg::STQ_DEPTH + 2; i++) begin
      add_row(op_store, lsu_pkg::addr_t'(8'h40 + i), $urandom(), 4'b1111, '0, 1'b0);
    end
    add_row(op_idle, 8'h00, '0, '0, 32'd2, 1'b0);
    for (int i = 0; i < lsu_pkg::STQ_DEPTH + 2; i++) add_row(op_commit, 8'h00, '0, '0, '0, 1'b0);
    add_row(op_idle, 8'h00, '0, '0, 32'd3, 1'b0);
    for (int i = 0; i < lsu_pkg::STQ_DEPTH + 2; i++) begin
      add_row(op_load, lsu_pkg::addr_t'(8'h40 + i), '0, '0, '0, 1'b1);
    end
    // Random mix on four words, queue kept well below full
    for (int n = 0; n < 32; n++) begin
      pick = $urandom_range(7);
      addr = lsu_pkg::addr_t'(8'h50 + $urandom_range(3));
      if (pick < 3 && model_q.size() < 5) begin
        add_row(op_store, addr, $urandom(), lsu_pkg::be_t'($urandom_range(15, 1)), '0, 1'b0);
      end else if (pick < 5 && model_q.size() != 0) begin
        add_row(op_commit, 8'h00, '0, '0, '0, 1'b0);
      end else if (pick == 5) begin
        add_row(op_flush, 8'h00, '0, '0, '0, 1'b0);
      end else begin
        add_row(op_load, addr, '0, '0, '0, 1'b1);
      end
    end
  endfunction

  // ======================================================================
  // Row drivers, each entered and left 1 ns after a rising edge
  // ======================================================================
  task automatic send_store(input row_t r);
    i_st_valid = 1'b1;
    i_st_addr  = r.addr;
    i_st_data  = r.data;
    i_st_be    = r.be;
    @(negedge i_clk);
    while (!o_st_ready) @(negedge i_clk);
    @(posedge i_clk);
    #1;
    i_st_valid = 1'b0;
  endtask

  task automatic request_load(input row_t r);
    i_ld_valid = 1'b1;
    i_ld_addr  = r.addr;
    @(negedge i_clk);
    while (!o_ld_ready) @(negedge i_clk);
    @(posedge i_clk);
    #1;
    i_ld_valid = 1'b0;
    exp_q.push_back(r.exp);
  endtask

  task automatic pulse_commit();
    i_commit = 1'b1;
    @(posedge i_clk);
    #1;
    i_commit = 1'b0;
  endtask

  task automatic pulse_flush();
    i_flush = 1'b1;
    @(posedge i_clk);
    #1;
    i_flush = 1'b0;
  endtask

  task automatic idle_cycle(input row_t r);
    @(negedge i_clk);
    check_bit("o_st_ready", o_st_ready, r.exp[0]);
    check_bit("o_ld_ready", o_ld_ready, r.exp[1]);
    @(posedge i_clk);
    #1;
  endtask

  // Loads must issue before the queue changes under them
  task automatic wait_responses();
    while (exp_q.size() != 0) begin
      @(posedge i_clk);
      #1;
    end
  endtask

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  initial begin
    i_ld_ready = 1'b1;
    forever begin
      @(posedge i_clk);
      #1;
      i_ld_ready = ($urandom % 4) != 0;  // Stall about one cycle in four
    end
  end

  // Response order, values and stability under stall
  initial begin : resp_monitor
    lsu_pkg::data_t held;
    bit             holding;
    holding = 1'b0;
    forever begin
      @(negedge i_clk);
      if (i_reset_n) begin
        if (holding) begin
          check_bit("o_ld_valid", o_ld_valid, 1'b1);
          check_data("o_ld_data", o_ld_data, held);
        end
        holding = o_ld_valid && !i_ld_ready;
        held    = o_ld_data;
        if (o_ld_valid && i_ld_ready) begin
          if (exp_q.size() == 0) report_problem("load response with no load outstanding");
          else check_data("o_ld_data", o_ld_data, exp_q.pop_front());
        end
      end
    end
  end

  initial begin
    wait (table_ready);
    repeat (rows.size() * 40) @(posedge i_clk);
    $display("Timeout: run did not finish within %0d cycles", rows.size() * 40);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h4968));
    i_reset_n  = 1'b0;
    i_st_valid = 1'b0;
    i_st_addr  = '0;
    i_st_data  = '0;
    i_st_be    = '0;
    i_ld_valid = 1'b0;
    i_ld_addr  = '0;
    i_commit   = 1'b0;
    i_flush    = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;
    foreach (rows[i]) begin
      if (rows[i].kind != op_load && rows[i].kind != op_idle) wait_responses();
      case (rows[i].kind)
        op_store:  send_store(rows[i]);
        op_commit: pulse_commit();
        op_flush:  pulse_flush();
        op_load:   request_load(rows[i]);
        default:   idle_cycle(rows[i]);
      endcase
    end
    wait_responses();
    $display("Error counts: data %0d, bit %0d, other %0d", data_errs, bit_errs, other_errs);
    if (total_errors() == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: lsu_top.sv
`timescale 1ns/1ns

module lsu_top (
  input  logic           i_clk,
  input  logic           i_reset_n,
  // Store request
  input  logic           i_st_valid,
  output logic           o_st_ready,
  input  lsu_pkg::addr_t i_st_addr,
  input  lsu_pkg::data_t i_st_data,
  input  lsu_pkg::be_t   i_st_be,
  // Load request
  input  logic           i_ld_valid,
  output logic           o_ld_ready,
  input  lsu_pkg::addr_t i_ld_addr,
  // Load response
  output logic           o_ld_valid,
  input  logic           i_ld_ready,
  output lsu_pkg::data_t o_ld_data,
  // Core control
  input  logic           i_commit,
  input  logic           i_flush
);

  // ===================================================================
  // Internal wires
  // ===================================================================
  lsu_pkg::st_req_t w_st_req;
  logic             w_st_valid;
  logic             w_st_ready;

  lsu_pkg::ld_req_t w_ld_req;
  logic             w_issue_valid;
  logic             w_issue_ready;

  lsu_pkg::be_t     w_fwd_mask;
  lsu_pkg::data_t   w_fwd_data;
  lsu_pkg::data_t   w_mem_data;

  logic             w_wr_valid;
  lsu_pkg::addr_t   w_wr_addr;
  lsu_pkg::data_t   w_wr_data;
  lsu_pkg::be_t     w_wr_be;

  lsu_skid #(.payload_t(lsu_pkg::st_req_t)) u_st_skid (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_valid   (i_st_valid),
    .o_ready   (o_st_ready),
    .i_data    ({i_st_addr, i_st_data, i_st_be}),
    .o_valid   (w_st_valid),
    .i_ready   (w_st_ready),
    .o_data    (w_st_req)
  );

  lsu_skid #(.payload_t(lsu_pkg::ld_req_t)) u_ld_skid (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_valid   (i_ld_valid),
    .o_ready   (o_ld_ready),
    .i_data    (i_ld_addr),
    .o_valid   (w_issue_valid),
    .i_ready   (w_issue_ready),
    .o_data    (w_ld_req)
  );

  lsu_stq u_stq (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_alloc_valid (w_st_valid),
    .o_alloc_ready (w_st_ready),
    .i_alloc_addr  (w_st_req.addr),
    .i_alloc_data  (w_st_req.data),
    .i_alloc_be    (w_st_req.be),
    .i_commit      (i_commit),
    .i_flush       (i_flush),
    .i_fwd_addr    (w_ld_req.addr),  // Searched in the issue cycle
    .o_fwd_mask    (w_fwd_mask),
    .o_fwd_data    (w_fwd_data),
    .o_wr_valid    (w_wr_valid),
    .o_wr_addr     (w_wr_addr),
    .o_wr_data     (w_wr_data),
    .o_wr_be       (w_wr_be)
  );

  lsu_dmem u_dmem (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_rd_addr  (w_ld_req.addr),
    .o_rd_data  (w_mem_data),
    .i_wr_valid (w_wr_valid),
    .i_wr_addr  (w_wr_addr),
    .i_wr_data  (w_wr_data),
    .i_wr_be    (w_wr_be)
  );

  lsu_ld_merge u_ld_merge (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_issue_valid (w_issue_valid),
    .o_issue_ready (w_issue_ready),
    .i_fwd_mask    (w_fwd_mask),
    .i_fwd_data    (w_fwd_data),
    .i_mem_data    (w_mem_data),
    .o_ld_valid    (o_ld_valid),
    .i_ld_ready    (i_ld_ready),
    .o_ld_data     (o_ld_data)
  );

endmodule

// File: lsu_ld_merge.sv
`timescale 1ns/1ns

module lsu_ld_merge (
  input  logic           i_clk,
  input  logic           i_reset_n,
  // Issue from the load skid
  input  logic           i_issue_valid,
  output logic           o_issue_ready,
  input  lsu_pkg::be_t   i_fwd_mask,
  input  lsu_pkg::data_t i_fwd_data,
  // Memory word, one cycle after issue
  input  lsu_pkg::data_t i_mem_data,
  // Load response
  output logic           o_ld_valid,
  input  logic           i_ld_ready,
  output lsu_pkg::data_t o_ld_data
);

  logic           r_valid;      // Result pending
  logic           r_fresh;      // First cycle, memory word still on the bus
  lsu_pkg::be_t   r_mask;
  lsu_pkg::data_t r_fwd_data;
  lsu_pkg::data_t r_hold_data;
  lsu_pkg::data_t w_merged;
  logic           w_issue;

  assign o_issue_ready = !r_valid || i_ld_ready;
  assign w_issue       = i_issue_valid && o_issue_ready;

  // Forwarded bytes win over memory
  always_comb begin
    for (int b = 0; b < lsu_pkg::BE_W; b++) begin
      w_merged[b*8 +: 8] = r_mask[b] ? r_fwd_data[b*8 +: 8] : i_mem_data[b*8 +: 8];
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= 1'b0;
      r_fresh <= 1'b0;
    end else if (w_issue) begin
      r_valid <= 1'b1;
      r_fresh <= 1'b1;
    end else begin
      r_fresh <= 1'b0;
      if (i_ld_ready) r_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_issue) begin
      r_mask     <= i_fwd_mask;
      r_fwd_data <= i_fwd_data;
    end
    if (r_fresh) begin
      r_hold_data <= w_merged;  // Keep result once memory moves on
    end
  end

  assign o_ld_valid = r_valid;
  assign o_ld_data  = r_fresh ? w_merged : r_hold_data;

  // Held response survives the switch to the hold register
  a_resp_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (o_ld_valid && !i_ld_ready) |=> (o_ld_valid && $stable(o_ld_data)));

endmodule

// File: lsu_dmem.sv
`timescale 1ns/1ns

module lsu_dmem (
  input  logic           i_clk,
  input  logic           i_reset_n,
  // Read port, one cycle latency
  input  lsu_pkg::addr_t i_rd_addr,
  output lsu_pkg::data_t o_rd_data,
  // Byte-enabled write port
  input  logic           i_wr_valid,
  input  lsu_pkg::addr_t i_wr_addr,
  input  lsu_pkg::data_t i_wr_data,
  input  lsu_pkg::be_t   i_wr_be
);

  lsu_pkg::data_t r_mem [lsu_pkg::MEM_WORDS];
  lsu_pkg::data_t r_rd_data;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      // Start from a known all-zero image
      for (int w = 0; w < lsu_pkg::MEM_WORDS; w++) begin
        r_mem[w] <= '0;
      end
      r_rd_data <= '0;
    end else begin
      r_rd_data <= r_mem[i_rd_addr];  // Old data on a same-word write
      if (i_wr_valid) begin
        for (int b = 0; b < lsu_pkg::BE_W; b++) begin
          if (i_wr_be[b]) begin
            r_mem[i_wr_addr][b*8 +: 8] <= i_wr_data[b*8 +: 8];
          end
        end
      end
    end
  end

  assign o_rd_data = r_rd_data;

endmodule

// File: lsu_stq.sv
`timescale 1ns/1ns

module lsu_stq (
  input  logic           i_clk,
  input  logic           i_reset_n,
  // Allocation in program order
  input  logic           i_alloc_valid,
  output logic           o_alloc_ready,
  input  lsu_pkg::addr_t i_alloc_addr,
  input  lsu_pkg::data_t i_alloc_data,
  input  lsu_pkg::be_t   i_alloc_be,
  // Core control
  input  logic           i_commit,
  input  logic           i_flush,
  // Load forwarding search
  input  lsu_pkg::addr_t i_fwd_addr,
  output lsu_pkg::be_t   o_fwd_mask,
  output lsu_pkg::data_t o_fwd_data,
  // Drain to memory
  output logic           o_wr_valid,
  output lsu_pkg::addr_t o_wr_addr,
  output lsu_pkg::data_t o_wr_data,
  output lsu_pkg::be_t   o_wr_be
);

  typedef logic [lsu_pkg::STQ_PTR_W-1:0] ptr_t;
  typedef logic [lsu_pkg::STQ_PTR_W:0]   cnt_t;  // Holds 0..STQ_DEPTH

  // ===================================================================
  // Entry storage and pointers
  // ===================================================================
  lsu_pkg::addr_t r_addr [lsu_pkg::STQ_DEPTH];
  lsu_pkg::data_t r_data [lsu_pkg::STQ_DEPTH];
  lsu_pkg::be_t   r_be   [lsu_pkg::STQ_DEPTH];

  ptr_t r_head;     // Oldest entry
  ptr_t r_tail;     // Next free slot
  ptr_t r_cmt_ptr;  // Oldest uncommitted entry
  cnt_t r_count;    // Valid entries
  cnt_t r_cmt_cnt;  // Committed, not yet drained

  logic w_alloc;
  logic w_drain;
  cnt_t w_uncmt;

  assign o_alloc_ready = (r_count != cnt_t'(lsu_pkg::STQ_DEPTH));
  assign w_alloc       = i_alloc_valid && o_alloc_ready;
  assign w_drain       = (r_cmt_cnt != '0);  // Head is committed
  assign w_uncmt       = r_count - r_cmt_cnt;

  always_ff @(posedge i_clk) begin
    if (w_alloc) begin
      r_addr[r_tail] <= i_alloc_addr;
      r_data[r_tail] <= i_alloc_data;
      r_be[r_tail]   <= i_alloc_be;
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head    <= '0;
      r_tail    <= '0;
      r_cmt_ptr <= '0;
      r_count   <= '0;
      r_cmt_cnt <= '0;
    end else begin
      if (w_drain) r_head <= r_head + 1'b1;
      if (i_commit) r_cmt_ptr <= r_cmt_ptr + 1'b1;
      r_cmt_cnt <= r_cmt_cnt + cnt_t'(i_commit) - cnt_t'(w_drain);

      if (i_flush) begin
        // Roll back to the commit point, a store arriving now is dropped too
        r_tail  <= r_cmt_ptr;
        r_count <= r_cmt_cnt - cnt_t'(w_drain);
      end else begin
        if (w_alloc) r_tail <= r_tail + 1'b1;
        r_count <= r_count + cnt_t'(w_alloc) - cnt_t'(w_drain);
      end
    end
  end

  // ===================================================================
  // Drain port
  // ===================================================================
  assign o_wr_valid = w_drain;
  assign o_wr_addr  = r_addr[r_head];
  assign o_wr_data  = r_data[r_head];
  assign o_wr_be    = r_be[r_head];

  // ===================================================================
  // Store-to-load forwarding
  // ===================================================================
  // Walk from oldest to youngest so a later match overwrites an older one
  always_comb begin
    ptr_t w_idx;
    logic w_hit;

    o_fwd_mask = '0;
    o_fwd_data = '0;
    for (int i = 0; i < lsu_pkg::STQ_DEPTH; i++) begin
      w_idx = r_head + ptr_t'(i);
      w_hit = (cnt_t'(i) < r_count) && (r_addr[w_idx] == i_fwd_addr);
      for (int b = 0; b < lsu_pkg::BE_W; b++) begin
        if (w_hit && r_be[w_idx][b]) begin
          o_fwd_mask[b]        = 1'b1;
          o_fwd_data[b*8 +: 8] = r_data[w_idx][b*8 +: 8];
        end
      end
    end
  end

  // ===================================================================
  // Checks
  // ===================================================================
  // Core may only commit stores it has handed over
  a_commit_has_entry: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_commit |-> (w_uncmt != '0));

  // Pointers and counters describe the same occupancy
  a_occupancy: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (ptr_t'(r_tail - r_head) == ptr_t'(r_count)) &&
    (ptr_t'(r_cmt_ptr - r_head) == ptr_t'(r_cmt_cnt)) &&
    (r_cmt_cnt <= r_count));

  a_commit_flush_excl: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(i_commit && i_flush));

endmodule

// File: lsu_skid.sv
`timescale 1ns/1ns

module lsu_skid #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     i_clk,
  input  logic     i_reset_n,
  // Upstream
  input  logic     i_valid,
  output logic     o_ready,
  input  payload_t i_data,
  // Downstream
  output logic     o_valid,
  input  logic     i_ready,
  output payload_t o_data
);

  payload_t   r_mem [2];
  logic       r_wr_ptr;
  logic       r_rd_ptr;
  logic [1:0] r_count;
  logic       w_empty;
  logic       w_push;
  logic       w_pop;

  assign w_empty = (r_count == 2'd0);
  assign o_ready = (r_count != 2'd2); // Decoded from a flop only

  // Bypass while empty
  assign o_valid = !w_empty || i_valid;
  assign o_data  = w_empty ? i_data : r_mem[r_rd_ptr];

  assign w_push = i_valid && o_ready && !(w_empty && i_ready);
  assign w_pop  = !w_empty && i_ready;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wr_ptr <= 1'b0;
      r_rd_ptr <= 1'b0;
      r_count  <= 2'd0;
    end else begin
      if (w_push) r_wr_ptr <= !r_wr_ptr;
      if (w_pop)  r_rd_ptr <= !r_rd_ptr;
      r_count <= r_count + 2'(w_push) - 2'(w_pop);
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_push) begin
      r_mem[r_wr_ptr] <= i_data;
    end
  end

  // Offered item must not change until taken
  a_hold_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (o_valid && !i_ready) |=> (o_valid && $stable(o_data)));

endmodule

// File: lsu_pkg.sv
package lsu_pkg;

  // ===================================================================
  // Sizes
  // ===================================================================
  localparam int ADDR_W    = 8;          // Word address
  localparam int DATA_W    = 32;
  localparam int BE_W      = DATA_W / 8; // One enable per byte
  localparam int STQ_DEPTH = 8;
  localparam int STQ_PTR_W = 3;
  localparam int MEM_WORDS = 256;

  // ===================================================================
  // Types
  // ===================================================================
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [BE_W-1:0]   be_t;

  // Store request as it travels through the skid buffer
  typedef struct packed {
    addr_t addr;
    data_t data;
    be_t   be;
  } st_req_t;

  // Load request, address only
  typedef struct packed {
    addr_t addr;
  } ld_req_t;

endpackage
